// ==== rtl/mb_config.svh ====
`ifndef MB_CONFIG_SVH
`define MB_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// axi4-lite register map
////////////////////////////////////////////////////////////////////////
`define MB_AXI_ADDR_W 4 // byte address bits on the slave port
`define MB_REG_BOOT_ADDR 4'h0 // prom address of next image
`define MB_REG_CTRL 4'h4 // bit 0 requests reboot
`define MB_REG_STATUS 4'h8 // busy and done counter

////////////////////////////////////////////////////////////////////////
// command path sizing
////////////////////////////////////////////////////////////////////////
`define MB_FIFO_DEPTH 4 // entries between generator and driver
`define MB_GUARD_CYCLES 2 // enabled idle cycles around a burst
`define MB_SEQ_LEN 18 // words in one reboot stream

`endif

// ==== rtl/mb_pkg.sv ====
package mb_pkg;

	////////////////////////////////////////////////////////////////////////
	// command stream payload
	////////////////////////////////////////////////////////////////////////

	// one config byte, msb first as written in the command table
	typedef logic [7:0] icap_word_t;

	// prom address for the warm boot
	typedef logic [23:0] boot_addr_t;

	// fifo entry, last marks word 18 of a sequence
	typedef struct packed {
		logic last; // final word of the burst
		icap_word_t word; // byte in logical order
	} fifo_entry_t;

	////////////////////////////////////////////////////////////////////////
	// bus response codes
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		resp_okay = 2'b00, // normal access
		resp_slverr = 2'b10 // unmapped or refused
	} axi_resp_t;

endpackage

// ==== rtl/mb_axil_regs.sv ====
`timescale 1ns/10ps
`include "mb_config.svh"

module mb_axil_regs
(
	input logic clk,
	input logic rst_n,
	input logic [`MB_AXI_ADDR_W-1:0] awaddr, // write address
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata, // write data
	input logic [3:0] wstrb, // byte lanes
	input logic wvalid,
	output logic wready,
	output mb_pkg::axi_resp_t bresp, // write response
	output logic bvalid,
	input logic bready,
	input logic [`MB_AXI_ADDR_W-1:0] araddr, // read address
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata, // read data
	output mb_pkg::axi_resp_t rresp, // read response
	output logic rvalid,
	input logic rready,
	input logic done, // sequence finished on icap
	output logic start, // one cycle reboot request
	output mb_pkg::boot_addr_t boot_addr // address for generator
);

	logic aw_held; // write address captured
	logic w_held; // write data captured
	logic [`MB_AXI_ADDR_W-1:0] aw_addr_q; // held write offset
	logic [31:0] w_data_q; // held write data
	logic [3:0] w_strb_q; // held byte enables
	logic wr_fire; // both halves here, commit write
	logic ctrl_go; // ctrl write with bit 0 set
	logic busy; // reboot in flight
	logic [7:0] done_cnt; // completed sequences, wraps
	mb_pkg::axi_resp_t wr_resp; // response for committed write
	mb_pkg::axi_resp_t rd_resp; // response for accepted read
	logic [31:0] rd_data; // decoded read value

	assign awready = !aw_held; // one address slot
	assign wready = !w_held; // one data slot
	assign arready = !rvalid; // no read pending
	assign wr_fire = aw_held && w_held && !bvalid; // waits out stalled bready
	assign ctrl_go = (aw_addr_q == `MB_REG_CTRL) && w_strb_q[0] && w_data_q[0];

	////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (aw_addr_q == `MB_REG_BOOT_ADDR || aw_addr_q == `MB_REG_STATUS)
			wr_resp = mb_pkg::resp_okay; // status writes ignored
		else if (aw_addr_q == `MB_REG_CTRL)
			wr_resp = (ctrl_go && busy) ? mb_pkg::resp_slverr : mb_pkg::resp_okay;
		else
			wr_resp = mb_pkg::resp_slverr; // unmapped
	end

	always_comb
	begin
		rd_data = '0; // unmapped and ctrl read zero
		rd_resp = mb_pkg::resp_okay;
		case (araddr)
			`MB_REG_BOOT_ADDR: rd_data = {8'h00, boot_addr}; // top byte zero
			`MB_REG_CTRL: rd_data = '0; // write only
			`MB_REG_STATUS: rd_data = {16'h0000, done_cnt, 7'h00, busy};
			default: rd_resp = mb_pkg::resp_slverr;
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			done_cnt <= 8'h00;
			boot_addr <= '0; // reads zero after reset
		end
		else
		begin
			start <= 1'b0; // single cycle pulse
			if (awvalid && awready)
				aw_held <= 1'b1;
			if (wvalid && wready)
				w_held <= 1'b1;
			if (done)
			begin
				busy <= 1'b0; // driver closed the burst
				done_cnt <= done_cnt + 8'd1;
			end
			if (wr_fire)
			begin
				aw_held <= 1'b0; // free both slots
				w_held <= 1'b0;
				bvalid <= 1'b1;
				if (aw_addr_q == `MB_REG_BOOT_ADDR)
				begin
					for (int i = 0; i < 3; i++)
					begin
						if (w_strb_q[i])
							boot_addr[i*8 +: 8] <= w_data_q[i*8 +: 8]; // lane merge
					end
				end
				if (ctrl_go && !busy)
				begin
					start <= 1'b1; // accepted only when idle
					busy <= 1'b1;
				end
			end
			else if (bvalid && bready)
				bvalid <= 1'b0;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	// held request and response payload
	always_ff @(posedge clk)
	begin
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready)
		begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
		if (wr_fire)
			bresp <= wr_resp;
		if (arvalid && arready)
		begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

endmodule

// ==== rtl/mb_seq_gen.sv ====
`timescale 1ns/10ps
`include "mb_config.svh"

module mb_seq_gen
(
	input logic clk,
	input logic rst_n,
	input logic start, // reboot request from registers
	input mb_pkg::boot_addr_t boot_addr, // target prom address
	input logic push_ready, // fifo has room
	output logic push_valid, // word on offer
	output mb_pkg::fifo_entry_t push_entry // word plus last flag
);

	localparam int IDX_W = $clog2(`MB_SEQ_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`MB_SEQ_LEN - 1);

	logic active; // stream in progress
	logic [IDX_W-1:0] idx; // current table position
	mb_pkg::boot_addr_t addr_q; // address latched at start
	mb_pkg::icap_word_t word; // table lookup result
	logic push_fire; // word accepted by fifo

	assign push_valid = active;
	assign push_fire = push_valid && push_ready;
	assign push_entry = '{last: (idx == LAST_IDX), word: word};

	////////////////////////////////////////////////////////////////////////
	// reboot command table
	////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (idx)
			0: word = 8'hAA; // sync
			1: word = 8'h99;
			2: word = 8'h32; // write general register 1
			3: word = 8'h61;
			4: word = addr_q[15:8]; // low address
			5: word = addr_q[7:0];
			6: word = 8'h32; // write general register 2
			7: word = 8'h81;
			8: word = 8'h0B; // read opcode and high address
			9: word = addr_q[23:16];
			10: word = 8'h30; // write command register
			11: word = 8'hA1;
			12: word = 8'h00; // reboot
			13: word = 8'h0E;
			14: word = 8'h20; // no-op
			15: word = 8'h00;
			16: word = 8'h20; // no-op
			17: word = 8'h00;
			default: word = 8'h20; // unreachable, no-op
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			idx <= '0;
		end
		else if (start)
		begin
			active <= 1'b1; // first offer next cycle
			idx <= '0;
		end
		else if (push_fire)
		begin
			if (idx == LAST_IDX)
				active <= 1'b0; // stream done
			else
				idx <= idx + 1'b1; // step only on accept
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			addr_q <= boot_addr; // stable for the whole stream
	end

endmodule

// ==== rtl/mb_word_fifo.sv ====
`timescale 1ns/10ps
`include "mb_config.svh"

module mb_word_fifo
(
	input logic clk,
	input logic rst_n,
	input logic push_valid, // generator offers entry
	input mb_pkg::fifo_entry_t push_entry,
	output logic push_ready, // not full
	output logic pop_valid, // not empty
	output mb_pkg::fifo_entry_t pop_entry, // head entry
	input logic pop_ready // driver takes head
);

	localparam int DEPTH = `MB_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

	mb_pkg::fifo_entry_t mem [DEPTH]; // storage, no reset
	logic [PTR_W-1:0] wr_ptr; // next slot to write
	logic [PTR_W-1:0] rd_ptr; // head slot
	logic [CNT_W-1:0] count; // occupancy
	logic push_fire;
	logic pop_fire;

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid = (count != '0); // pushed entry visible next cycle
	assign pop_entry = mem[rd_ptr];
	assign push_fire = push_valid && push_ready;
	assign pop_fire = pop_valid && pop_ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_fire)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1; // wraps any depth
			if (pop_fire)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			if (push_fire && !pop_fire)
				count <= count + 1'b1;
			else if (pop_fire && !push_fire)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_fire)
			mem[wr_ptr] <= push_entry;
	end

endmodule

// ==== rtl/mb_icap_port.sv ====
`timescale 1ns/10ps
`include "mb_config.svh"

module mb_icap_port
(
	input logic clk,
	input logic rst_n,
	input logic pop_valid, // fifo has a word
	input mb_pkg::fifo_entry_t pop_entry, // head word
	output logic pop_ready, // take head this cycle
	output logic icap_ce_n, // active low enable
	output logic icap_write_n, // active low write
	output logic [7:0] icap_i, // icap bit order, d0 on bit 7
	output logic icap_clk_en, // gate for the config clock
	output logic done // one cycle at end of burst
);

	localparam int CNT_W = $clog2(`MB_GUARD_CYCLES + 1);
	localparam logic [CNT_W-1:0] LEAD_LAST = CNT_W'(`MB_GUARD_CYCLES - 1);
	localparam logic [CNT_W-1:0] TRAIL_LAST = CNT_W'(`MB_GUARD_CYCLES);

	typedef enum logic [1:0] {
		st_idle, // clock gated off
		st_lead, // guard before first word
		st_data, // streaming words
		st_trail // guard after last word
	} state_t;

	state_t state;
	logic [CNT_W-1:0] guard_cnt; // cycles spent in a guard state
	logic take; // word popped this cycle
	logic [7:0] rev; // swapped byte for the pins

	// pop on the last lead cycle so the first word follows the guard directly
	assign pop_ready = (state == st_data) || (state == st_lead && guard_cnt == LEAD_LAST);
	assign take = pop_valid && pop_ready;

	always_comb
	begin
		for (int i = 0; i < 8; i++)
			rev[i] = pop_entry.word[7-i]; // logical bit 7 lands on d0
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			guard_cnt <= '0;
			icap_ce_n <= 1'b1;
			icap_write_n <= 1'b1;
			icap_clk_en <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			icap_ce_n <= !take; // idle cycle when fifo runs dry
			icap_write_n <= !take;
			guard_cnt <= guard_cnt + 1'b1;
			case (state)
				st_idle:
				begin
					guard_cnt <= '0;
					if (pop_valid)
					begin
						state <= st_lead; // enable clock next cycle
						icap_clk_en <= 1'b1;
					end
				end
				st_lead:
					if (guard_cnt == LEAD_LAST)
						state <= st_data; // first word may already be popped
				st_data:
				begin
					guard_cnt <= '0;
					if (take && pop_entry.last)
						state <= st_trail; // last word shows in first trail cycle
				end
				default:
					if (guard_cnt == TRAIL_LAST)
					begin
						state <= st_idle;
						icap_clk_en <= 1'b0;
						done <= 1'b1; // same cycle the clock drops
					end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			icap_i <= rev;
	end

endmodule

// ==== rtl/mb_top.sv ====
`timescale 1ns/10ps
`include "mb_config.svh"

module mb_top
(
	input logic clk,
	input logic rst_n,
	input logic [`MB_AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output mb_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input logic [`MB_AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output mb_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,
	output logic icap_ce_n, // to icap ce
	output logic icap_write_n, // to icap write
	output logic [7:0] icap_i, // to icap data in
	output logic icap_clk_en // gates the icap clock
);

	logic start; // regs to generator
	mb_pkg::boot_addr_t boot_addr;
	logic push_valid; // generator to fifo
	logic push_ready;
	mb_pkg::fifo_entry_t push_entry;
	logic pop_valid; // fifo to driver
	logic pop_ready;
	mb_pkg::fifo_entry_t pop_entry;
	logic done; // driver back to regs

	mb_axil_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.done(done), .start(start), .boot_addr(boot_addr)
	);

	mb_seq_gen u_seq (
		.clk(clk), .rst_n(rst_n), .start(start), .boot_addr(boot_addr),
		.push_ready(push_ready), .push_valid(push_valid), .push_entry(push_entry)
	);

	mb_word_fifo u_fifo (
		.clk(clk), .rst_n(rst_n),
		.push_valid(push_valid), .push_entry(push_entry), .push_ready(push_ready),
		.pop_valid(pop_valid), .pop_entry(pop_entry), .pop_ready(pop_ready)
	);

	mb_icap_port u_port (
		.clk(clk), .rst_n(rst_n),
		.pop_valid(pop_valid), .pop_entry(pop_entry), .pop_ready(pop_ready),
		.icap_ce_n(icap_ce_n), .icap_write_n(icap_write_n), .icap_i(icap_i),
		.icap_clk_en(icap_clk_en), .done(done)
	);

endmodule

// ==== sim/tb_mb_axil.svh ====
`ifndef TB_MB_AXIL_SVH
`define TB_MB_AXIL_SVH

//////////////////////////////////////////////////////////////////////
// axi4-lite master tasks, called 1 ns after a rising edge
//////////////////////////////////////////////////////////////////////

// random bready/rready hold-off when the row asks for it
task automatic ready_delay();
	int wait_n;
	wait_n = slow_ready ? ($unsigned($random(seed)) % 4) : 0;
	repeat (wait_n)
	begin
		@(posedge clk);
		#1;
	end
endtask

task automatic axi_write(input logic [`MB_AXI_ADDR_W-1:0] addr, input logic [31:0] data,
	input logic [3:0] strb, output mb_pkg::axi_resp_t resp);
	logic aw_hit;
	logic w_hit;
	awaddr = addr;
	wdata = data;
	wstrb = strb;
	awvalid = 1'b1;
	wvalid = 1'b1;
	while (awvalid || wvalid)
	begin
		aw_hit = awvalid && awready; // ready is stable between edges
		w_hit = wvalid && wready;
		@(posedge clk);
		#1;
		if (aw_hit)
			awvalid = 1'b0;
		if (w_hit)
			wvalid = 1'b0;
	end
	while (!bvalid)
	begin
		@(posedge clk);
		#1;
	end
	ready_delay();
	bready = 1'b1;
	resp = bresp; // held while bvalid
	@(posedge clk);
	#1;
	bready = 1'b0;
endtask

task automatic axi_read(input logic [`MB_AXI_ADDR_W-1:0] addr, output logic [31:0] data,
	output mb_pkg::axi_resp_t resp);
	logic ar_hit;
	araddr = addr;
	arvalid = 1'b1;
	while (arvalid)
	begin
		ar_hit = arready;
		@(posedge clk);
		#1;
		if (ar_hit)
			arvalid = 1'b0;
	end
	while (!rvalid)
	begin
		@(posedge clk);
		#1;
	end
	ready_delay();
	rready = 1'b1;
	data = rdata;
	resp = rresp;
	@(posedge clk);
	#1;
	rready = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// typed compares
//////////////////////////////////////////////////////////////////////

task automatic check_word(input mb_pkg::icap_word_t got, input mb_pkg::icap_word_t exp,
	input string what);
	if (got !== exp)
	begin
		err_word++;
		$display("ERROR @%0t: %s got %02h expected %02h", $time, what, got, exp);
	end
endtask

task automatic check_addr(input mb_pkg::boot_addr_t got, input mb_pkg::boot_addr_t exp,
	input string what);
	if (got !== exp)
	begin
		err_addr++;
		$display("ERROR @%0t: %s got %06h expected %06h", $time, what, got, exp);
	end
endtask

task automatic check_resp(input mb_pkg::axi_resp_t got, input mb_pkg::axi_resp_t exp,
	input string what);
	if (got !== exp)
	begin
		err_resp++;
		$display("ERROR @%0t: %s got resp %b expected %b", $time, what, got, exp);
	end
endtask

task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp)
	begin
		err_data++;
		$display("ERROR @%0t: %s got %08h expected %08h", $time, what, got, exp);
	end
endtask

`endif

// ==== sim/tb_mb_top.sv ====
`timescale 1ns/10ps
`include "mb_config.svh"

module tb_mb_top;

	typedef struct packed {
		mb_pkg::boot_addr_t addr; // value on wdata[23:0]
		logic [3:0] strb; // byte lanes for the write
		logic slow; // random ready hold-off
	} row_t;

	localparam int ROWS = 5;
	localparam int TIMEOUT_CYC = ROWS * 200 + 1000;

	row_t rows [ROWS] = '{
		'{24'h123456, 4'hF, 1'b0},
		'{24'hABCDEF, 4'h1, 1'b1},
		'{24'h5A5A5A, 4'h6, 1'b1},
		'{24'hFEDCBA, 4'h4, 1'b0},
		'{24'h00C0DE, 4'hB, 1'b1}
	};

	logic clk = 1'b0;
	logic rst_n;
	logic [`MB_AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	mb_pkg::axi_resp_t bresp;
	logic bvalid;
	logic bready;
	logic [`MB_AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	mb_pkg::axi_resp_t rresp;
	logic rvalid;
	logic rready;
	logic icap_ce_n;
	logic icap_write_n;
	logic [7:0] icap_i;
	logic icap_clk_en;

	integer seed = 32'h18bea40d;
	logic slow_ready; // current row flag
	int err_word;
	int err_addr;
	int err_resp;
	int err_data;
	int err_other;
	mb_pkg::icap_word_t capture [$]; // bytes seen on icap, logical order
	int lead_idle; // enabled ce_n high before first word
	int trail_idle; // enabled ce_n high after latest word
	logic seen_word;

	`include "tb_mb_axil.svh"

	mb_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.icap_ce_n(icap_ce_n), .icap_write_n(icap_write_n), .icap_i(icap_i),
		.icap_clk_en(icap_clk_en)
	);

	always #5 clk = ~clk; // 10 ns period

	// reboot stream as the command table defines it
	function automatic mb_pkg::icap_word_t cmd_word(input int idx, input mb_pkg::boot_addr_t a);
		case (idx)
			0: return 8'hAA; // sync
			1: return 8'h99;
			2: return 8'h32; // gen reg 1
			3: return 8'h61;
			4: return a[15:8];
			5: return a[7:0];
			6: return 8'h32; // gen reg 2
			7: return 8'h81;
			8: return 8'h0B;
			9: return a[23:16];
			10: return 8'h30; // cmd reg
			11: return 8'hA1;
			12: return 8'h00;
			13: return 8'h0E; // reboot
			default: return (idx % 2 == 0) ? 8'h20 : 8'h00; // two no-ops
		endcase
	endfunction

	function automatic mb_pkg::boot_addr_t merge_lanes(input mb_pkg::boot_addr_t old_a,
		input mb_pkg::boot_addr_t new_a, input logic [3:0] strb);
		mb_pkg::boot_addr_t r;
		r = old_a;
		for (int b = 0; b < 3; b++)
			if (strb[b])
				r[b*8 +: 8] = new_a[b*8 +: 8]; // lane 3 has no storage
		return r;
	endfunction

	function automatic mb_pkg::icap_word_t unswap_bits(input logic [7:0] pins);
		mb_pkg::icap_word_t r;
		for (int i = 0; i < 8; i++)
			r[i] = pins[7-i]; // d0 carries logical bit 7
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// icap monitor, mid-cycle sampling of registered pins
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (rst_n && icap_clk_en)
		begin
			if (icap_write_n !== icap_ce_n)
			begin
				err_other++;
				$display("ERROR @%0t: icap write_n does not follow ce_n", $time);
			end
			if (!icap_ce_n)
			begin
				capture.push_back(unswap_bits(icap_i));
				seen_word = 1'b1;
				trail_idle = 0; // gap was mid-stream
			end
			else if (!seen_word)
				lead_idle++;
			else
				trail_idle++;
		end
	end

	// watchdog
	initial
	begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("test timed out after %0d cycles", TIMEOUT_CYC);
		$display("Done: errors found");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rd;
		mb_pkg::axi_resp_t resp;
		mb_pkg::boot_addr_t exp_addr;
		int total;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		slow_ready = 1'b0;
		err_word = 0;
		err_addr = 0;
		err_resp = 0;
		err_data = 0;
		err_other = 0;
		lead_idle = 0;
		trail_idle = 0;
		seen_word = 1'b0;
		exp_addr = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// reset state
		if (!(icap_ce_n === 1'b1 && icap_write_n === 1'b1 && icap_clk_en === 1'b0))
		begin
			err_other++;
			$display("ERROR @%0t: icap pins are not idle after reset", $time);
		end
		if (!(awready === 1'b1 && wready === 1'b1 && arready === 1'b1 && bvalid === 1'b0
			&& rvalid === 1'b0))
		begin
			err_other++;
			$display("ERROR @%0t: axi handshake outputs wrong after reset", $time);
		end
		axi_read(`MB_REG_BOOT_ADDR, rd, resp);
		check_data(rd, 32'h0, "boot_addr after reset");
		check_resp(resp, mb_pkg::resp_okay, "boot_addr read resp");
		axi_read(`MB_REG_STATUS, rd, resp);
		check_data(rd, 32'h0, "status after reset");
		check_resp(resp, mb_pkg::resp_okay, "status read resp");

		// unmapped offset
		axi_write(4'hC, 32'hFFFF_FFFF, 4'hF, resp);
		check_resp(resp, mb_pkg::resp_slverr, "write to 0xC");
		axi_read(4'hC, rd, resp);
		check_resp(resp, mb_pkg::resp_slverr, "read of 0xC");
		check_data(rd, 32'h0, "read data of 0xC");

		for (int r = 0; r < ROWS; r++)
		begin
			slow_ready = rows[r].slow;
			exp_addr = merge_lanes(exp_addr, rows[r].addr, rows[r].strb);
			axi_write(`MB_REG_BOOT_ADDR, {8'h5C, rows[r].addr}, rows[r].strb, resp);
			check_resp(resp, mb_pkg::resp_okay, "boot_addr write");
			axi_read(`MB_REG_BOOT_ADDR, rd, resp);
			check_resp(resp, mb_pkg::resp_okay, "boot_addr read");
			check_data(rd, {8'h00, exp_addr}, "boot_addr readback");
			check_addr(rd[23:0], exp_addr, "merged boot address");

			capture.delete();
			lead_idle = 0;
			trail_idle = 0;
			seen_word = 1'b0;
			axi_write(`MB_REG_CTRL, 32'h1, 4'h1, resp);
			check_resp(resp, mb_pkg::resp_okay, "ctrl start when idle");
			axi_read(`MB_REG_STATUS, rd, resp);
			check_data(rd & 32'h1, 32'h1, "status busy after start");
			axi_write(`MB_REG_CTRL, 32'h1, 4'h1, resp);
			check_resp(resp, mb_pkg::resp_slverr, "ctrl start when busy");

			// poll until the driver reports done
			do
				axi_read(`MB_REG_STATUS, rd, resp);
			while (rd[0] === 1'b1);
			check_data(rd, {16'h0, 8'(r + 1), 8'h00}, "status after sequence");

			// config clock is gated off again once done has fired
			if (icap_clk_en !== 1'b0 || icap_ce_n !== 1'b1)
			begin
				err_other++;
				$display("ERROR @%0t: icap clock enable still on after done", $time);
			end

			if (capture.size() != `MB_SEQ_LEN)
			begin
				err_other++;
				$display("ERROR @%0t: captured %0d icap words instead of %0d", $time,
					capture.size(), `MB_SEQ_LEN);
			end
			else
				for (int k = 0; k < `MB_SEQ_LEN; k++)
					check_word(capture[k], cmd_word(k, exp_addr), $sformatf("icap word %0d", k));
			if (lead_idle < `MB_GUARD_CYCLES || trail_idle < `MB_GUARD_CYCLES)
			begin
				err_other++;
				$display("ERROR @%0t: guard cycles too short, lead %0d trail %0d", $time,
					lead_idle, trail_idle);
			end
		end

		total = err_word + err_addr + err_resp + err_data + err_other;
		$display("error counts: word %0d addr %0d resp %0d data %0d other %0d",
			err_word, err_addr, err_resp, err_data, err_other);
		if (total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+rtl
+incdir+sim
rtl/mb_pkg.sv
rtl/mb_axil_regs.sv
rtl/mb_seq_gen.sv
rtl/mb_word_fifo.sv
rtl/mb_icap_port.sv
rtl/mb_top.sv
sim/tb_mb_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mb_top -Mdir obj_dir -o tb_mb_top
	@out=$$(./obj_dir/tb_mb_top); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
